/* hw/riscv_opcodes.svh */
`ifndef RISCV_OPCODES_SVH
`define RISCV_OPCODES_SVH

// RV32I base opcodes
`define OPC_ARI_RTYPE 7'b0110011
`define OPC_ARI_ITYPE 7'b0010011
`define OPC_LOAD      7'b0000011
`define OPC_STORE     7'b0100011
`define OPC_BRANCH    7'b1100011
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111
`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111
`define OPC_CSR       7'b1110011

// Store funct3
`define FNC_SB 3'b000
`define FNC_SH 3'b001
`define FNC_SW 3'b010

// Branch funct3
`define FNC_BEQ  3'b000
`define FNC_BNE  3'b001
`define FNC_BLT  3'b100
`define FNC_BGE  3'b101
`define FNC_BLTU 3'b110
`define FNC_BGEU 3'b111

// addi x0, x0, 0
`define NOP 32'h0000_0013

`endif

/* hw/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // Region code from addr[31:28]
    typedef enum logic [3:0] {
        REGION_DMEM   = 4'b0001,
        REGION_IMEM   = 4'b0010,
        REGION_MIRROR = 4'b0011,
        REGION_BIOS   = 4'b0100,
        REGION_IO     = 4'b1000
    } mem_region_e;

    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_HALF  = 2'd1,
        SIZE_WORD  = 2'd2,
        SIZE_UNDEF = 2'd3
    } mem_size_e;

    // Store data source
    typedef enum logic [1:0] {
        DIN_RS2       = 2'd0,
        DIN_WB        = 2'd1,
        DIN_DONT_CARE = 2'd2
    } din_sel_e;

    typedef struct packed {
        logic      imem_en;
        logic      dmem_en;
        logic      bios_en;
        logic      io_en;
        logic      is_load;
        logic      is_store;
        mem_size_e size;
        din_sel_e  din_sel;
        logic      br_inst;
        logic      bubble;
    } mem_ctrl_t;

    typedef struct packed {
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        misaligned;
    } store_data_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] addr;
        logic [31:0] inst;
        logic [31:0] rs2_data;
        logic [31:0] wb_inst;
        logic [31:0] wb_data;
    } mem_in_t;

    typedef struct packed {
        logic        imem_en;
        logic        dmem_en;
        logic        bios_en;
        logic [3:0]  we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_port_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] paddr;
        logic [31:0] pwdata;
        logic [3:0]  pstrb;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

/* hw/mem_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "riscv_opcodes.svh"

module mem_control (
    input  wire                 clk,
    input  wire mem_pkg::mem_in_t req,
    output mem_pkg::mem_ctrl_t  ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] rs2;
    logic [6:0] wb_opcode;
    logic [4:0] wb_rd;
    logic       has_rs2;
    logic       wb_has_rd;
    mem_pkg::mem_region_e region;

    assign opcode    = req.inst[6:0];
    assign funct3    = req.inst[14:12];
    assign rs2       = req.inst[24:20];
    assign wb_opcode = req.wb_inst[6:0];
    assign wb_rd     = req.wb_inst[11:7];
    assign region    = mem_pkg::mem_region_e'(req.addr[31:28]);

    // x0 never forwards
    assign has_rs2 = rs2 != 5'd0;
    assign wb_has_rd = wb_opcode != `OPC_STORE &&
                       wb_opcode != `OPC_BRANCH &&
                       wb_opcode != `OPC_CSR;

    always_comb begin
        ctrl         = '0;
        ctrl.size    = mem_pkg::SIZE_UNDEF;
        ctrl.din_sel = mem_pkg::DIN_DONT_CARE;
        ctrl.bubble  = req.inst == `NOP;

        case (opcode)
            `OPC_LOAD: begin
                ctrl.is_load = 1'b1;
                // imem is not readable from the data side
                case (region)
                    mem_pkg::REGION_IO:     ctrl.io_en   = 1'b1;
                    mem_pkg::REGION_BIOS:   ctrl.bios_en = 1'b1;
                    mem_pkg::REGION_DMEM:   ctrl.dmem_en = 1'b1;
                    mem_pkg::REGION_MIRROR: ctrl.dmem_en = 1'b1;
                    default: ;
                endcase
            end
            `OPC_STORE: begin
                ctrl.is_store = 1'b1;
                case (region)
                    mem_pkg::REGION_IO:   ctrl.io_en   = 1'b1;
                    mem_pkg::REGION_DMEM: ctrl.dmem_en = 1'b1;
                    // imem writable only while running from bios
                    mem_pkg::REGION_IMEM: ctrl.imem_en = req.pc[30];
                    mem_pkg::REGION_MIRROR: begin
                        ctrl.imem_en = req.pc[30];
                        ctrl.dmem_en = 1'b1;
                    end
                    default: ;
                endcase

                if (has_rs2 && wb_has_rd && rs2 == wb_rd) begin
                    ctrl.din_sel = mem_pkg::DIN_WB;
                end else begin
                    ctrl.din_sel = mem_pkg::DIN_RS2;
                end

                case (funct3)
                    `FNC_SB: ctrl.size = mem_pkg::SIZE_BYTE;
                    `FNC_SH: ctrl.size = mem_pkg::SIZE_HALF;
                    `FNC_SW: ctrl.size = mem_pkg::SIZE_WORD;
                    default: ctrl.size = mem_pkg::SIZE_UNDEF;
                endcase
            end
            `OPC_BRANCH: begin
                case (funct3)
                    `FNC_BEQ, `FNC_BNE, `FNC_BLT,
                    `FNC_BGE, `FNC_BLTU, `FNC_BGEU: ctrl.br_inst = 1'b1;
                    default: ;
                endcase
            end
            // No memory or branch effect
            `OPC_ARI_RTYPE, `OPC_ARI_ITYPE, `OPC_JAL, `OPC_JALR,
            `OPC_LUI, `OPC_AUIPC, `OPC_CSR: ;
            default: ;
        endcase
    end

    // Data-side regions are mutually exclusive
    assert property (@(posedge clk) $onehot0({ctrl.io_en, ctrl.bios_en, ctrl.dmem_en}));

endmodule

`default_nettype wire

/* hw/store_align.sv */
`timescale 1ns/1ps
`default_nettype none

module store_align (
    input  wire                    clk,
    input  wire mem_pkg::mem_in_t  req,
    input  wire mem_pkg::din_sel_e din_sel,
    input  wire mem_pkg::mem_size_e size,
    output mem_pkg::store_data_t   store
);

    logic [31:0] data;
    logic [1:0]  offset;

    // Forwarded value from writeback or register file
    assign data   = (din_sel == mem_pkg::DIN_WB) ? req.wb_data : req.rs2_data;
    assign offset = req.addr[1:0];

    always_comb begin
        store.wdata      = data << {offset, 3'b000};
        store.wstrb      = 4'b0000;
        store.misaligned = 1'b0;

        case (size)
            mem_pkg::SIZE_BYTE: begin
                store.wstrb = 4'b0001 << offset;
            end
            mem_pkg::SIZE_HALF: begin
                store.misaligned = offset[0];
                if (!offset[0]) begin
                    store.wstrb = 4'b0011 << offset;
                end
            end
            mem_pkg::SIZE_WORD: begin
                store.misaligned = offset != 2'd0;
                if (offset == 2'd0) begin
                    store.wstrb = 4'b1111;
                end
            end
            default: ;
        endcase
    end

    assert property (@(posedge clk) store.misaligned |-> store.wstrb == 4'b0000);

endmodule

`default_nettype wire

/* hw/mem_port_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_port_ctrl (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      req_valid,
    output logic                     req_ready,
    input  wire [31:0]               addr,
    input  wire mem_pkg::mem_ctrl_t  ctrl,
    input  wire mem_pkg::store_data_t store,
    output mem_pkg::mem_port_t       mem_port,
    output mem_pkg::apb_req_t        apb_req,
    input  wire mem_pkg::apb_rsp_t   apb_rsp,
    output logic [31:0]              io_rdata,
    output logic                     io_rdata_valid
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS
    } state_e;

    state_e      state;
    logic        accept;
    logic        valid_op;
    logic        port_hit;
    logic        apb_done;
    logic        imem_q;
    logic        dmem_q;
    logic        bios_q;
    logic [3:0]  we_q;
    logic [31:0] addr_q;
    logic [31:0] wdata_q;
    logic [3:0]  strb_q;
    logic        pwrite_q;

    assign req_ready = state == ST_IDLE;
    assign accept    = req_valid && req_ready;
    // Misaligned stores are dropped entirely
    assign valid_op  = accept && (ctrl.is_load || ctrl.is_store) &&
                       !(ctrl.is_store && store.misaligned);
    assign port_hit  = ctrl.imem_en || ctrl.dmem_en || ctrl.bios_en;
    assign apb_done  = state == ST_ACCESS && apb_rsp.pready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= ST_IDLE;
            imem_q         <= 1'b0;
            dmem_q         <= 1'b0;
            bios_q         <= 1'b0;
            we_q           <= 4'b0000;
            io_rdata_valid <= 1'b0;
        end else begin
            imem_q         <= valid_op && ctrl.imem_en;
            dmem_q         <= valid_op && ctrl.dmem_en;
            bios_q         <= valid_op && ctrl.bios_en;
            we_q           <= (valid_op && ctrl.is_store && port_hit) ? store.wstrb : 4'b0000;
            io_rdata_valid <= apb_done && !pwrite_q;

            case (state)
                ST_IDLE: begin
                    if (valid_op && ctrl.io_en) begin
                        state <= ST_SETUP;
                    end
                end
                ST_SETUP: state <= ST_ACCESS;
                ST_ACCESS: begin
                    if (apb_rsp.pready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request payload held while the FSM is busy
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q   <= addr;
            wdata_q  <= store.wdata;
            strb_q   <= ctrl.is_store ? store.wstrb : 4'b0000;
            pwrite_q <= ctrl.is_store;
        end
        if (apb_done) begin
            io_rdata <= apb_rsp.prdata;
        end
    end

    assign mem_port = '{imem_en: imem_q, dmem_en: dmem_q, bios_en: bios_q,
                        we: we_q, addr: addr_q, wdata: wdata_q};

    assign apb_req = '{psel: state != ST_IDLE, penable: state == ST_ACCESS,
                       pwrite: pwrite_q, paddr: addr_q, pwdata: wdata_q, pstrb: strb_q};

    // Transfer fields hold until the slave completes
    assert property (@(posedge clk) disable iff (!rst_n)
        apb_req.psel && !apb_rsp.pready |=>
            $stable({apb_req.pwrite, apb_req.paddr, apb_req.pwdata, apb_req.pstrb}));

endmodule

`default_nettype wire

/* hw/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    req_valid,
    output logic                   req_ready,
    input  wire mem_pkg::mem_in_t  req,
    output mem_pkg::mem_port_t     mem_port,
    output mem_pkg::apb_req_t      apb_req,
    input  wire mem_pkg::apb_rsp_t apb_rsp,
    output logic [31:0]            io_rdata,
    output logic                   io_rdata_valid,
    output logic                   br_inst,
    output logic                   bubble
);

    mem_pkg::mem_ctrl_t   ctrl;
    mem_pkg::store_data_t store;

    mem_control u_mem_control (
        .clk  (clk),
        .req  (req),
        .ctrl (ctrl)
    );

    store_align u_store_align (
        .clk     (clk),
        .req     (req),
        .din_sel (ctrl.din_sel),
        .size    (ctrl.size),
        .store   (store)
    );

    mem_port_ctrl u_mem_port_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .addr           (req.addr),
        .ctrl           (ctrl),
        .store          (store),
        .mem_port       (mem_port),
        .apb_req        (apb_req),
        .apb_rsp        (apb_rsp),
        .io_rdata       (io_rdata),
        .io_rdata_valid (io_rdata_valid)
    );

    // Branch and bubble flags are only reported
    assign br_inst = ctrl.br_inst;
    assign bubble  = ctrl.bubble;

endmodule

`default_nettype wire

/* verification/mem_stage_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "riscv_opcodes.svh"

module mem_stage_checker (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     req_valid,
    input  wire                     req_ready,
    input  wire mem_pkg::mem_in_t   req,
    input  wire mem_pkg::mem_port_t mem_port,
    input  wire mem_pkg::apb_req_t  apb_req,
    input  wire mem_pkg::apb_rsp_t  apb_rsp,
    input  wire [31:0]              io_rdata,
    input  wire                     io_rdata_valid,
    input  wire                     br_inst,
    input  wire                     bubble,
    output int                      errors
);

    typedef struct packed {
        logic        imem;
        logic        dmem;
        logic        bios;
        logic        io;
        logic        write;
        logic [3:0]  strb;
        logic [31:0] addr;
        logic [31:0] wdata;
    } access_t;

    localparam logic [1:0] PH_IDLE   = 2'd0;
    localparam logic [1:0] PH_SETUP  = 2'd1;
    localparam logic [1:0] PH_ACCESS = 2'd2;

    int          err_count = 0;
    logic [1:0]  phase = PH_IDLE;
    access_t     exp_port = '0;
    access_t     io_q[$];
    logic        exp_rvalid = 1'b0;
    logic [31:0] exp_rdata = '0;

    assign errors = err_count;

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
            err_count++;
        end
    endtask

    // Expected effect of one accepted request
    function automatic access_t predict(mem_pkg::mem_in_t r);
        access_t     a;
        logic [6:0]  opc;
        logic [6:0]  wb_opc;
        logic [3:0]  region;
        logic [1:0]  off;
        logic        fwd;
        logic        drop;
        opc    = r.inst[6:0];
        wb_opc = r.wb_inst[6:0];
        region = r.addr[31:28];
        off    = r.addr[1:0];
        a      = '0;
        drop   = 1'b0;
        fwd    = r.inst[24:20] != 5'd0 && r.inst[24:20] == r.wb_inst[11:7] &&
                 !(wb_opc inside {`OPC_STORE, `OPC_BRANCH, `OPC_CSR});
        a.addr  = r.addr;
        a.wdata = (fwd ? r.wb_data : r.rs2_data) << (8 * off);
        if (opc == `OPC_STORE) begin
            a.write = 1'b1;
            case (r.inst[14:12])
                `FNC_SB: a.strb = 4'b0001 << off;
                `FNC_SH: begin
                    drop   = off[0];
                    a.strb = off[0] ? 4'b0000 : 4'b0011 << off;
                end
                `FNC_SW: begin
                    drop   = off != 2'd0;
                    a.strb = drop ? 4'b0000 : 4'b1111;
                end
                default: a.strb = 4'b0000;
            endcase
            if (!drop) begin
                a.io   = region == 4'h8;
                a.dmem = region == 4'h1 || region == 4'h3;
                // Instruction memory only writable when running from bios
                a.imem = (region == 4'h2 || region == 4'h3) && r.pc[30];
            end
        end else if (opc == `OPC_LOAD) begin
            a.io   = region == 4'h8;
            a.bios = region == 4'h4;
            a.dmem = region == 4'h1 || region == 4'h3;
        end
        return a;
    endfunction

    always @(negedge clk) begin : model_step
        access_t    a;
        logic       accept;
        logic       is_branch;
        is_branch = req.inst[6:0] == `OPC_BRANCH &&
                    (req.inst[14:12] inside {`FNC_BEQ, `FNC_BNE, `FNC_BLT,
                                             `FNC_BGE, `FNC_BLTU, `FNC_BGEU});

        compare("mem_port.imem_en", 32'(exp_port.imem), 32'(mem_port.imem_en));
        compare("mem_port.dmem_en", 32'(exp_port.dmem), 32'(mem_port.dmem_en));
        compare("mem_port.bios_en", 32'(exp_port.bios), 32'(mem_port.bios_en));
        compare("mem_port.we", 32'(exp_port.strb), 32'(mem_port.we));
        if (exp_port.imem || exp_port.dmem || exp_port.bios) begin
            compare("mem_port.addr", exp_port.addr, mem_port.addr);
            if (exp_port.write) begin
                compare("mem_port.wdata", exp_port.wdata, mem_port.wdata);
            end
        end
        compare("req_ready", 32'(phase == PH_IDLE), 32'(req_ready));
        compare("apb_req.psel", 32'(phase != PH_IDLE), 32'(apb_req.psel));
        compare("apb_req.penable", 32'(phase == PH_ACCESS), 32'(apb_req.penable));
        if (phase != PH_IDLE) begin
            compare("apb_req.paddr", io_q[0].addr, apb_req.paddr);
            compare("apb_req.pwrite", 32'(io_q[0].write), 32'(apb_req.pwrite));
            compare("apb_req.pstrb", 32'(io_q[0].strb), 32'(apb_req.pstrb));
            if (io_q[0].write) begin
                compare("apb_req.pwdata", io_q[0].wdata, apb_req.pwdata);
            end
        end
        compare("io_rdata_valid", 32'(exp_rvalid), 32'(io_rdata_valid));
        if (exp_rvalid) begin
            compare("io_rdata", exp_rdata, io_rdata);
        end
        compare("br_inst", 32'(is_branch), 32'(br_inst));
        compare("bubble", 32'(req.inst == `NOP), 32'(bubble));

        // Advance the model across the coming rising edge
        exp_rvalid = 1'b0;
        exp_port   = '0;
        if (!rst_n) begin
            phase = PH_IDLE;
            io_q.delete();
        end else begin
            accept = phase == PH_IDLE && req_valid;
            if (phase == PH_ACCESS && apb_rsp.pready) begin
                exp_rvalid = !io_q[0].write;
                exp_rdata  = apb_rsp.prdata;
                io_q.delete(0);
                phase = PH_IDLE;
            end else if (phase == PH_SETUP) begin
                phase = PH_ACCESS;
            end
            if (accept) begin
                a = predict(req);
                if (a.io) begin
                    io_q.push_back(a);
                    phase = PH_SETUP;
                end else if (a.imem || a.dmem || a.bios) begin
                    exp_port = a;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verification/tb_mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "riscv_opcodes.svh"

module tb_mem_stage;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               req_valid;
    logic               req_ready;
    mem_pkg::mem_in_t   req;
    mem_pkg::mem_port_t mem_port;
    mem_pkg::apb_req_t  apb_req;
    mem_pkg::apb_rsp_t  apb_rsp = '0;
    logic [31:0]        io_rdata;
    logic               io_rdata_valid;
    logic               br_inst;
    logic               bubble;
    int                 chk_errors;
    int                 tb_errors = 0;
    int                 wait_states = 0;

    always #2 clk = ~clk;

    mem_stage dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req            (req),
        .mem_port       (mem_port),
        .apb_req        (apb_req),
        .apb_rsp        (apb_rsp),
        .io_rdata       (io_rdata),
        .io_rdata_valid (io_rdata_valid),
        .br_inst        (br_inst),
        .bubble         (bubble)
    );

    mem_stage_checker u_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req            (req),
        .mem_port       (mem_port),
        .apb_req        (apb_req),
        .apb_rsp        (apb_rsp),
        .io_rdata       (io_rdata),
        .io_rdata_valid (io_rdata_valid),
        .br_inst        (br_inst),
        .bubble         (bubble),
        .errors         (chk_errors)
    );

    // APB slave with 0 to 3 wait states per transfer
    always @(posedge clk) begin
        #1;
        if (!rst_n || apb_rsp.pready) begin
            apb_rsp.pready = 1'b0;
        end else if (apb_req.psel && !apb_req.penable) begin
            wait_states = $urandom % 4;
        end else if (apb_req.psel) begin
            if (wait_states == 0) begin
                apb_rsp.pready = 1'b1;
                apb_rsp.prdata = $urandom;
            end else begin
                wait_states = wait_states - 1;
            end
        end
    end

    function automatic logic [6:0] pick_opcode();
        case ($urandom % 16)
            0, 1, 2, 3: return `OPC_LOAD;
            4, 5, 6, 7: return `OPC_STORE;
            8:          return `OPC_BRANCH;
            9:          return `OPC_ARI_RTYPE;
            10:         return `OPC_ARI_ITYPE;
            11:         return `OPC_JAL;
            12:         return `OPC_JALR;
            13:         return `OPC_LUI;
            14:         return `OPC_AUIPC;
            default:    return `OPC_CSR;
        endcase
    endfunction

    function automatic mem_pkg::mem_in_t random_req();
        mem_pkg::mem_in_t r;
        logic [31:0]      rnd;
        r.pc        = $urandom;
        r.inst      = $urandom;
        r.inst[6:0] = pick_opcode();
        if ($urandom % 16 == 0) begin
            r.inst = `NOP;
        end
        rnd    = $urandom;
        r.addr = $urandom;
        case (rnd[2:0])
            3'd0:       r.addr[31:28] = 4'h1;
            3'd1:       r.addr[31:28] = 4'h2;
            3'd2:       r.addr[31:28] = 4'h3;
            3'd3:       r.addr[31:28] = 4'h4;
            3'd4, 3'd5: r.addr[31:28] = 4'h8;
            default:    r.addr[31:28] = rnd[7:4];
        endcase
        r.rs2_data     = $urandom;
        r.wb_data      = $urandom;
        r.wb_inst      = $urandom;
        r.wb_inst[6:0] = pick_opcode();
        // Half the time writeback targets the store's rs2
        if ($urandom % 2 == 0) begin
            r.wb_inst[11:7] = r.inst[24:20];
        end
        return r;
    endfunction

    task automatic send(input mem_pkg::mem_in_t r, output logic timed_out);
        int waited;
        req       = r;
        req_valid = 1'b1;
        waited    = 0;
        while (!req_ready && waited < 100) begin
            @(posedge clk);
            #1;
            waited++;
        end
        timed_out = !req_ready;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    initial begin
        logic timed_out;
        int   waited;
        void'($urandom(1));
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        timed_out = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < 2000 && !timed_out; i++) begin
            if ($urandom % 4 == 0) begin
                @(posedge clk);
                #1;
            end
            send(random_req(), timed_out);
        end
        if (timed_out) begin
            $display("Timeout: req_ready stayed low for 100 cycles on a request");
            tb_errors++;
        end

        // Let a trailing io transfer finish
        waited = 0;
        while (!req_ready && waited < 100) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!req_ready) begin
            $display("Timeout: the last io transfer did not complete within 100 cycles");
            tb_errors++;
        end
        repeat (3) @(posedge clk);
        #1;

        $display("Errors: %0d from checks, %0d from testbench", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hw
hw/mem_pkg.sv
hw/mem_control.sv
hw/store_align.sv
hw/mem_port_ctrl.sv
hw/mem_stage.sv
verification/mem_stage_checker.sv
verification/tb_mem_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_mem_stage -f vlog.f -o sim_mem_stage
./obj_dir/sim_mem_stage | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
